// File: sources.f
+incdir+.
ifetch_pkg.sv
icache_store.sv
bus_refill.sv
fetch_ctrl.sv
ifetch_top.sv
ifetch_properties.sv
tb_clock.sv
tb_ifetch.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_ifetch -f sources.f -o tb_ifetch_sim \
	&& ./obj_dir/tb_ifetch_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "ALL TESTS PASSED" sim.log \
	&& echo "run.sh: simulation passed" \
	|| { echo "run.sh: simulation failed"; exit 1; }

// File: tb_ifetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_consts.svh"

module tb_ifetch
	import ifetch_pkg::*;
();

	localparam int          CLOCK_NS = 40;
	localparam logic [31:0] LCG_SEED = 32'd75;
	localparam word_t       DATA_KEY = 32'hA5C3_5A3C;
	localparam int          RANDOM_FETCHES = 40;

	// A fetch needs at most the sweep plus a full bus wait.
	localparam int FETCH_LIMIT     = `IF_LINES + 2 * `IF_BUS_TIMEOUT + 10;
	localparam int FETCH_COUNT     = 80;
	localparam int FETCH_WORST     = `IF_BUS_TIMEOUT + 6;
	localparam int WATCHDOG_CYCLES = FETCH_COUNT * FETCH_WORST + 3 * `IF_LINES + 200;

	logic   clock;
	logic   power_reset;
	logic   run_reset = 1'b0;
	logic   dut_reset;
	addr_t  pc = '0;
	logic   stall = 1'b1;
	logic   bus_ready = 1'b0;
	word_t  bus_rdata = '0;
	logic   ready;
	word_t  rdata;
	logic   bus_request;
	addr_t  bus_address;
	count_t hit_count;
	count_t miss_count;

	// Bus model state.
	logic [31:0] delay_seed = LCG_SEED;
	logic        bus_busy = 1'b0;
	int          bus_wait = 0;

	// Mirror of the cache tags and the profiling counters.
	logic   model_valid [`IF_LINES];
	tag_t   model_tag [`IF_LINES];
	count_t model_hits;
	count_t model_misses;

	logic [31:0] pc_seed = LCG_SEED;
	int          error_count = 0;
	int          errors_at_start = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	int          last_latency;
	logic        last_saw_request;

	assign dut_reset = power_reset | run_reset;

	tb_clock #(.PERIOD_NS(CLOCK_NS), .RESET_CYCLES(5)) clock_gen (
		.o_clock (clock),
		.o_reset (power_reset)
	);

	ifetch_top i_ifetch_top (
		.i_clock       (clock),
		.i_reset       (dut_reset),
		.i_pc          (pc),
		.i_stall       (stall),
		.i_bus_ready   (bus_ready),
		.i_bus_rdata   (bus_rdata),
		.o_ready       (ready),
		.o_rdata       (rdata),
		.o_bus_request (bus_request),
		.o_bus_address (bus_address),
		.o_hit_count   (hit_count),
		.o_miss_count  (miss_count)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Memory model, answers each request after 1 to 6 cycles.
	always @(posedge clock) begin
		if (dut_reset) begin
			bus_ready <= 1'b0;
			bus_busy  <= 1'b0;
		end else begin
			bus_ready <= 1'b0;
			if (bus_busy) begin
				if (bus_wait == 0) begin
					bus_ready <= 1'b1;
					bus_rdata <= bus_address ^ DATA_KEY;
					bus_busy  <= 1'b0;
				end else begin
					bus_wait <= bus_wait - 1;
				end
			end else if (bus_request && !bus_ready) begin
				// The CPU holds the missing PC for the whole refill.
				check_equal("o_bus_address", bus_address, pc);
				bus_busy   <= 1'b1;
				bus_wait   <= int'(delay_seed[23:16] % 8'd6);
				delay_seed <= lcg_next(delay_seed);
			end
		end
	end

	task automatic check_equal(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		assert (got === expected) else begin
			$display("[FAIL] %0t %s: got %h, expected %h", $time, name, got, expected);
			error_count++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic expected);
		assert (got === expected) else begin
			$display("[FAIL] %0t %s: got %b, expected %b", $time, name, got, expected);
			error_count++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("Check failed at %0t: %s", $time, what);
			error_count++;
		end
	endtask

	task automatic clear_model();
		for (int i = 0; i < `IF_LINES; i++) begin
			model_valid[i] = 1'b0;
			model_tag[i]   = '0;
		end
		model_hits   = '0;
		model_misses = '0;
	endtask

	// Presents a PC and waits for the answer. Called on a rising edge.
	task automatic fetch(input addr_t fetch_pc, input logic stall_on_refill);
		index_t idx;
		tag_t   tag;
		logic   expect_hit;
		logic   got_answer;
		int     cycles;
		idx        = fetch_pc[`IF_INDEX_W+1:2];
		tag        = fetch_pc[`IF_ADDR_W-1:`IF_INDEX_W+2];
		expect_hit = model_valid[idx] && (model_tag[idx] == tag);
		pc    <= fetch_pc;
		stall <= 1'b0;
		cycles = 0;
		got_answer = 1'b0;
		last_saw_request = 1'b0;
		while (!got_answer && cycles < FETCH_LIMIT) begin
			@(posedge clock);
			cycles++;
			if (bus_request) begin
				last_saw_request = 1'b1;
				// A stall raised during a refill must not lose the answer.
				if (stall_on_refill) begin
					stall <= 1'b1;
				end
			end
			got_answer = ready;
		end
		last_latency = cycles;
		if (!got_answer) begin
			$display("Fetch of pc %h got no answer within %0d cycles", fetch_pc, FETCH_LIMIT);
			error_count++;
		end else begin
			check_equal("o_rdata", rdata, fetch_pc ^ DATA_KEY);
			check_flag("o_bus_request seen", last_saw_request, !expect_hit);
			if (expect_hit) begin
				check_equal("hit latency", cycles, 32'd2);
				model_hits++;
			end else begin
				model_misses++;
				model_valid[idx] = 1'b1;
				model_tag[idx]   = tag;
			end
		end
	endtask

	// Stall is raised in the lookup cycle and held for a number of cycles.
	task automatic hold_stall(input addr_t fetch_pc, input int cycles);
		pc    <= fetch_pc;
		stall <= 1'b0;
		@(posedge clock);
		stall <= 1'b1;
		repeat (cycles) begin
			@(posedge clock);
			check_flag("o_ready", ready, 1'b0);
			check_flag("o_bus_request", bus_request, 1'b0);
		end
	endtask

	task automatic pause_and_check_counters();
		stall <= 1'b1;
		@(posedge clock);
		check_equal("o_hit_count", hit_count, model_hits);
		check_equal("o_miss_count", miss_count, model_misses);
	endtask

	task automatic finish_test(input string name);
		int errors_now;
		errors_now = error_count + int'(i_ifetch_top.protocol_checks.failures);
		if (errors_now == errors_at_start) begin
			tests_passed++;
			$display("Test %s: ok", name);
		end else begin
			tests_failed++;
			$display("Test %s: %0d errors", name, errors_now - errors_at_start);
		end
		errors_at_start = errors_now;
	endtask

	initial begin
		addr_t cached_pc;
		addr_t rand_pc;
		int    total_errors;
		$timeformat(-9, 0, " ns", 0);
		clear_model();
		cached_pc = '0;
		do begin
			@(posedge clock);
		end while (power_reset);

		fetch(32'h0000_1000, 1'b0);
		check_true(last_latency > `IF_LINES,
			"first fetch answered before the clear sweep ended");
		pause_and_check_counters();
		finish_test("reset sweep");

		for (int k = 1; k < 12; k++) begin
			fetch(addr_t'(32'h0000_1000 + k * 4), 1'b0);
		end
		pause_and_check_counters();
		finish_test("miss fill");

		for (int k = 0; k < 12; k++) begin
			fetch(addr_t'(32'h0000_1000 + k * 4), 1'b0);
			pause_and_check_counters();
		end
		finish_test("hit repeat");

		// Same index, next tag up.
		fetch(addr_t'(32'h0000_1000 + (`IF_LINES << 2)), 1'b0);
		check_flag("o_bus_request seen on alias", last_saw_request, 1'b1);
		pause_and_check_counters();
		fetch(32'h0000_1000, 1'b0);
		check_flag("o_bus_request seen on evicted pc", last_saw_request, 1'b1);
		pause_and_check_counters();
		finish_test("alias miss");

		hold_stall(32'h0000_1004, 8);
		fetch(32'h0000_1004, 1'b0);
		hold_stall(32'h0000_3000, 8);
		fetch(32'h0000_3000, 1'b1);
		pause_and_check_counters();
		finish_test("stall");

		// Eight indexes with four tags each, so hits and evictions mix.
		for (int n = 0; n < RANDOM_FETCHES; n++) begin
			pc_seed = lcg_next(pc_seed);
			rand_pc = 32'h0000_2000 | (addr_t'(pc_seed[18:16]) << 2)
				| (addr_t'(pc_seed[20:19]) << (`IF_INDEX_W + 2));
			fetch(rand_pc, 1'b0);
			cached_pc = rand_pc;
		end
		pause_and_check_counters();
		finish_test("random mix");

		run_reset <= 1'b1;
		repeat (5) @(posedge clock);
		run_reset <= 1'b0;
		clear_model();
		fetch(cached_pc, 1'b0);
		check_flag("o_bus_request seen after reset", last_saw_request, 1'b1);
		check_true(last_latency > `IF_LINES,
			"fetch after reset answered before the sweep ended");
		pause_and_check_counters();
		finish_test("mid-run reset");

		total_errors = error_count + int'(i_ifetch_top.protocol_checks.failures);
		$display("Summary: %0d ok, %0d with errors, %0d check errors, %0d property failures",
			tests_passed, tests_failed, error_count, i_ifetch_top.protocol_checks.failures);
		if (tests_failed == 0 && total_errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

	// Watchdog.
	initial begin
		#(WATCHDOG_CYCLES * CLOCK_NS);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 5
) (
	output logic o_clock,
	output logic o_reset
);

	initial begin
		o_clock = 1'b0;
		o_reset = 1'b1;
		// Reset is released on a rising edge, like any other driven input.
		repeat (RESET_CYCLES) @(posedge o_clock);
		o_reset <= 1'b0;
	end

	always #(PERIOD_NS / 2) o_clock = ~o_clock;

endmodule

`default_nettype wire

// File: ifetch_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_consts.svh"

module ifetch_properties (
	input wire i_clock,
	input wire i_reset,
	input wire i_stall,
	input wire i_bus_ready,
	input wire i_ready,
	input wire i_bus_request
);

	int unsigned failures = 0;
	int          sweep_cycles;

	// Cycles since the last reset, saturating at the sweep length.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			sweep_cycles <= 0;
		end else if (sweep_cycles < `IF_LINES) begin
			sweep_cycles <= sweep_cycles + 1;
		end
	end

	// Nothing is answered or requested while the lines are cleared.
	sweep_quiet: assert property (@(posedge i_clock) disable iff (i_reset)
		(sweep_cycles < `IF_LINES) |-> (!i_ready && !i_bus_request))
	else begin
		$error("ready or bus request seen during the clear sweep");
		failures++;
	end

	// A stalled CPU only gets an answer from a refill already on the bus.
	stall_no_ready: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_stall && !i_bus_request) |-> !i_ready)
	else begin
		$error("ready seen while the CPU stalls");
		failures++;
	end

	// The request level is held until the bus answers.
	request_held: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_bus_request && !i_bus_ready) |=> i_bus_request)
	else begin
		$error("bus request dropped before the bus answered");
		failures++;
	end

	request_drops: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_bus_request && i_bus_ready) |=> !i_bus_request)
	else begin
		$error("bus request still high after the bus answered");
		failures++;
	end

	// Ready is a single-cycle pulse.
	ready_pulse: assert property (@(posedge i_clock) disable iff (i_reset)
		i_ready |=> !i_ready)
	else begin
		$error("ready held for more than one cycle");
		failures++;
	end

endmodule

bind ifetch_top ifetch_properties protocol_checks (
	.i_clock       (i_clock),
	.i_reset       (i_reset),
	.i_stall       (i_stall),
	.i_bus_ready   (i_bus_ready),
	.i_ready       (o_ready),
	.i_bus_request (o_bus_request)
);

`default_nettype wire

// File: ifetch_top.sv
`timescale 1ns/1ps
`default_nettype none

module ifetch_top
	import ifetch_pkg::*;
(
	input  wire        i_clock,
	input  wire        i_reset,
	input  wire addr_t i_pc,
	input  wire        i_stall,
	input  wire        i_bus_ready,
	input  wire word_t i_bus_rdata,
	output logic       o_ready,
	output word_t      o_rdata,
	output logic       o_bus_request,
	output addr_t      o_bus_address,
	output count_t     o_hit_count,
	output count_t     o_miss_count
);

	// Store read path.
	index_t rd_index;
	logic   line_valid;
	tag_t   line_tag;
	word_t  line_data;
	logic   init_done;

	// Refill path.
	logic  refill_start;
	addr_t refill_addr;
	logic  fill;
	addr_t fill_addr;
	word_t fill_data;

	icache_store i_icache_store (
		.i_clock     (i_clock),
		.i_reset     (i_reset),
		.i_rd_index  (rd_index),
		.i_fill      (fill),
		.i_fill_addr (fill_addr),
		.i_fill_data (fill_data),
		.o_valid     (line_valid),
		.o_tag       (line_tag),
		.o_data      (line_data),
		.o_init_done (init_done)
	);

	bus_refill i_bus_refill (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_start       (refill_start),
		.i_addr        (refill_addr),
		.i_bus_ready   (i_bus_ready),
		.i_bus_rdata   (i_bus_rdata),
		.o_bus_request (o_bus_request),
		.o_bus_address (o_bus_address),
		.o_fill        (fill),
		.o_fill_addr   (fill_addr),
		.o_fill_data   (fill_data)
	);

	fetch_ctrl i_fetch_ctrl (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_pc           (i_pc),
		.i_stall        (i_stall),
		.i_init_done    (init_done),
		.i_line_valid   (line_valid),
		.i_line_tag     (line_tag),
		.i_line_data    (line_data),
		.i_fill         (fill),
		.i_fill_data    (fill_data),
		.o_rd_index     (rd_index),
		.o_refill_start (refill_start),
		.o_refill_addr  (refill_addr),
		.o_ready        (o_ready),
		.o_rdata        (o_rdata),
		.o_hit_count    (o_hit_count),
		.o_miss_count   (o_miss_count)
	);

endmodule

`default_nettype wire

// File: fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_consts.svh"

module fetch_ctrl
	import ifetch_pkg::*;
(
	input  wire         i_clock,
	input  wire         i_reset,
	input  wire addr_t  i_pc,
	input  wire         i_stall,
	input  wire         i_init_done,
	input  wire         i_line_valid,
	input  wire tag_t   i_line_tag,
	input  wire word_t  i_line_data,
	input  wire         i_fill,
	input  wire word_t  i_fill_data,
	output index_t      o_rd_index,
	output logic        o_refill_start,
	output addr_t       o_refill_addr,
	output logic        o_ready,
	output word_t       o_rdata,
	output count_t      o_hit_count,
	output count_t      o_miss_count
);

	fetch_state_t state;
	fetch_state_t next_state;

	tag_t pc_tag;
	logic tag_match;
	logic lookup_hit;
	logic lookup_miss;

	assign pc_tag     = i_pc[`IF_ADDR_W-1:`IF_INDEX_W+2];
	assign o_rd_index = i_pc[`IF_INDEX_W+1:2];

	// The line read in FS_IDLE comes back in FS_LOOKUP.
	assign tag_match   = i_line_valid && (i_line_tag == pc_tag);
	assign lookup_hit  = (state == FS_LOOKUP) && !i_stall && tag_match;
	assign lookup_miss = (state == FS_LOOKUP) && !i_stall && !tag_match;

	// Word-aligned address for the bus.
	assign o_refill_addr = {i_pc[`IF_ADDR_W-1:2], 2'b00};

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= FS_IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state     = state;
		o_ready        = 1'b0;
		o_rdata        = '0;
		o_refill_start = 1'b0;

		case (state)
			FS_IDLE: begin
				// Wait for the clear sweep before serving anything.
				if (i_init_done && !i_stall) begin
					next_state = FS_LOOKUP;
				end
			end

			FS_LOOKUP: begin
				if (i_stall) begin
					next_state = FS_IDLE;
				end else if (tag_match) begin
					o_ready    = 1'b1;
					o_rdata    = i_line_data;
					next_state = FS_IDLE;
				end else begin
					o_refill_start = 1'b1;
					next_state     = FS_REFILL;
				end
			end

			FS_REFILL: begin
				// Stall is ignored here, the bus word is forwarded as it lands.
				if (i_fill) begin
					o_ready    = 1'b1;
					o_rdata    = i_fill_data;
					next_state = FS_IDLE;
				end
			end

			default: begin
				next_state = FS_IDLE;
			end
		endcase
	end

	// Profiling counters. A refill answer is not a second event.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_hit_count  <= '0;
			o_miss_count <= '0;
		end else begin
			if (lookup_hit) begin
				o_hit_count <= o_hit_count + 1'b1;
			end
			if (lookup_miss) begin
				o_miss_count <= o_miss_count + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: bus_refill.sv
`timescale 1ns/1ps
`default_nettype none

module bus_refill
	import ifetch_pkg::*;
(
	input  wire        i_clock,
	input  wire        i_reset,
	input  wire        i_start,
	input  wire addr_t i_addr,
	input  wire        i_bus_ready,
	input  wire word_t i_bus_rdata,
	output logic       o_bus_request,
	output addr_t      o_bus_address,
	output logic       o_fill,
	output addr_t      o_fill_addr,
	output word_t      o_fill_data
);

	addr_t miss_addr;

	// Request rises the cycle after start and drops the cycle after ready.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_bus_request <= 1'b0;
		end else if (i_start) begin
			o_bus_request <= 1'b1;
		end else if (o_bus_request && i_bus_ready) begin
			o_bus_request <= 1'b0;
		end
	end

	// Miss address held for the whole request.
	always_ff @(posedge i_clock) begin
		if (i_start) begin
			miss_addr <= i_addr;
		end
	end

	assign o_bus_address = miss_addr;

	// Fill strobe in the same cycle as the bus answer.
	assign o_fill      = o_bus_request & i_bus_ready;
	assign o_fill_addr = miss_addr;
	assign o_fill_data = i_bus_rdata;

endmodule

`default_nettype wire

// File: icache_store.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_consts.svh"

module icache_store
	import ifetch_pkg::*;
(
	input  wire         i_clock,
	input  wire         i_reset,
	input  wire index_t i_rd_index,
	input  wire         i_fill,
	input  wire addr_t  i_fill_addr,
	input  wire word_t  i_fill_data,
	output logic        o_valid,
	output tag_t        o_tag,
	output word_t       o_data,
	output logic        o_init_done
);

	logic  valid_mem [`IF_LINES];
	tag_t  tag_mem   [`IF_LINES];
	word_t data_mem  [`IF_LINES];

	index_t sweep_index;
	logic   wr_en;
	index_t wr_index;
	logic   wr_valid;
	tag_t   wr_tag;

	// Clear sweep, one line per cycle, restarted by every reset.
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			sweep_index <= '0;
			o_init_done <= 1'b0;
		end else if (!o_init_done) begin
			sweep_index <= sweep_index + 1'b1;
			if (sweep_index == index_t'(`IF_LINES - 1)) begin
				o_init_done <= 1'b1;
			end
		end
	end

	// Sweep owns the write port until done, then fills take it.
	always_comb begin
		if (o_init_done) begin
			wr_en    = i_fill;
			wr_index = i_fill_addr[`IF_INDEX_W+1:2];
			wr_valid = 1'b1;
			wr_tag   = i_fill_addr[`IF_ADDR_W-1:`IF_INDEX_W+2];
		end else begin
			wr_en    = 1'b1;
			wr_index = sweep_index;
			wr_valid = 1'b0;
			wr_tag   = '0;
		end
	end

	// Block memory with a registered read.
	always_ff @(posedge i_clock) begin
		if (wr_en) begin
			valid_mem[wr_index] <= wr_valid;
			tag_mem[wr_index]   <= wr_tag;
			data_mem[wr_index]  <= i_fill_data;
		end
		o_valid <= valid_mem[i_rd_index];
		o_tag   <= tag_mem[i_rd_index];
		o_data  <= data_mem[i_rd_index];
	end

endmodule

`default_nettype wire

// File: ifetch_pkg.sv
`default_nettype none

`include "ifetch_consts.svh"

package ifetch_pkg;

	// Byte address and instruction word.
	typedef logic [`IF_ADDR_W-1:0] addr_t;
	typedef logic [`IF_ADDR_W-1:0] word_t;

	// Line index, address bits 2 upward.
	typedef logic [`IF_INDEX_W-1:0] index_t;

	// Address bits above the index.
	typedef logic [`IF_ADDR_W-`IF_INDEX_W-3:0] tag_t;

	// Profiling counter.
	typedef logic [31:0] count_t;

	typedef enum logic [1:0] {
		FS_IDLE   = 2'd0,
		FS_LOOKUP = 2'd1,
		FS_REFILL = 2'd2
	} fetch_state_t;

endpackage

`default_nettype wire

// File: ifetch_consts.svh
`ifndef IFETCH_CONSTS_SVH
`define IFETCH_CONSTS_SVH

// Address and instruction word width.
`define IF_ADDR_W 32

// Line index width. Each line holds one word.
`define IF_INDEX_W 6

// Number of cache lines.
`define IF_LINES (1 << `IF_INDEX_W)

// Worst-case number of cycles the bus takes to answer a request.
// Bounds the miss latency seen by the CPU.
`define IF_BUS_TIMEOUT 6

`endif
